// ==== logic/fpu_pkg.sv ====
package fpu_pkg;

  // binary32 field layout
  localparam int EXP_W    = 8;    // exponent field
  localparam int MAN_W    = 23;   // stored fraction
  localparam int SIG_W    = 24;   // fraction plus hidden bit
  localparam int EXP_BIAS = 127;

  // canonical quiet nan fraction, only the top fraction bit set
  localparam logic [MAN_W-1:0] QNAN_MAN = {1'b1, {(MAN_W-1){1'b0}}};

  // operations the unit knows about
  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_mul
  } fpu_op_e;

  // one ieee-754 single precision word
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] man;
  } fp32_t;

  // operand class flags from the exponent and fraction fields
  typedef struct packed {
    logic nan;
    logic inf;
    logic zero;
    logic subnormal;  // exp field zero with a nonzero fraction
  } fp_class_t;

  // operand after unpacking, ready for the datapaths
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;   // effective exponent, 1 for subnormals
    logic [SIG_W-1:0] sig;   // hidden bit only set for normal operands
    fp32_t            raw;   // untouched input word, nan pass-through uses it
    fp_class_t        cls;
  } fp_operand_t;

  // leading zero count of a 48 bit vector
  // callers pad narrower values with zeros at the bottom
  // all zero input gives 48
  function automatic logic [5:0] lzc(input logic [47:0] v);
    logic [5:0] cnt;
    cnt = 6'd48;
    // ascending scan, the highest set bit is the last one to write cnt
    for (int i = 0; i < 48; i++) begin
      if (v[i]) begin
        cnt = 6'(47 - i);
      end
    end
    return cnt;
  endfunction

endpackage

// ==== logic/fp_unpack.sv ====
`timescale 1ns/10ps

module fp_unpack import fpu_pkg::*; (
  input  fp32_t       word,
  output fp_operand_t opnd
);

  logic exp_zero;   // exponent field all zeros
  logic exp_ones;   // exponent field all ones
  logic man_zero;   // fraction field all zeros
  logic is_normal;

  assign exp_zero  = (word.exp == '0);
  assign exp_ones  = (word.exp == '1);
  assign man_zero  = (word.man == '0);
  assign is_normal = !exp_zero && !exp_ones;

  always_comb begin
    // class decode
    opnd.cls.nan       = exp_ones && !man_zero;
    opnd.cls.inf       = exp_ones &&  man_zero;
    opnd.cls.zero      = exp_zero &&  man_zero;
    opnd.cls.subnormal = exp_zero && !man_zero;

    opnd.sign = word.sign;

    // subnormals are 0.f x 2^-126, same scale as a biased exponent of 1
    // zero keeps exponent 0 and never wins alignment against a real number
    if (opnd.cls.subnormal) begin
      opnd.exp = EXP_W'(1);
    end else begin
      opnd.exp = word.exp;
    end

    opnd.sig = {is_normal, word.man};  // hidden bit
    opnd.raw = word;                   // kept for nan pass-through
  end

endmodule

// ==== logic/fp_addsub.sv ====
`timescale 1ns/10ps

module fp_addsub import fpu_pkg::*; (
  input  fp_operand_t a,
  input  fp_operand_t b,
  input  logic        sub,   // high selects a - b
  output fp32_t       res
);

  // mantissa vectors are [25:-3]
  // bit 25 sign, bit 24 carry, bit 23 hidden, [-1:-3] guard round sticky
  logic             a_small;         // a has the smaller exponent and is shifted
  logic [EXP_W-1:0] exp_big;
  logic [EXP_W-1:0] exp_diff;
  logic [4:0]       shamt;
  logic [55:0]      align_ext;       // shifted significand over the bits that fell out
  logic [25:-3]     small_aligned;
  logic [25:-3]     a_m;
  logic [25:-3]     b_m;
  logic [25:-3]     a_signed;
  logic [25:-3]     b_signed;
  logic [25:-3]     sum;
  logic [25:-3]     sum_abs;
  logic [25:-3]     m_carry;
  logic [EXP_W-1:0] e_carry;
  logic [5:0]       zcount;
  logic [5:0]       norm_shift;
  logic [25:-3]     m_shl;
  logic [EXP_W-1:0] e_shl;
  logic [25:-3]     m_norm;
  logic             guard;
  logic             rnd;
  logic             sticky;
  logic             round_up;
  logic [25:0]      m_rounded;
  logic [25:0]      m_renorm;
  logic [EXP_W-1:0] e_renorm;
  logic [EXP_W-1:0] e_final;

  // alignment
  assign a_small  = (a.exp < b.exp);
  assign exp_big  = a_small ? b.exp : a.exp;
  assign exp_diff = a_small ? (b.exp - a.exp) : (a.exp - b.exp);
  assign shamt    = (exp_diff > EXP_W'(28)) ? 5'd28 : exp_diff[4:0];  // 28 empties the window

  assign align_ext     = {2'b00, (a_small ? a.sig : b.sig), 30'd0} >> shamt;
  assign small_aligned = {align_ext[55:28], |align_ext[27:0]};  // sticky ORs all lost bits

  assign a_m = a_small ? small_aligned : {2'b00, a.sig, 3'b000};
  assign b_m = a_small ? {2'b00, b.sig, 3'b000} : small_aligned;

  // two's complement add, then magnitude
  assign a_signed = a.sign ? -a_m : a_m;
  assign b_signed = b.sign ? -b_m : b_m;
  assign sum      = sub ? (a_signed - b_signed) : (a_signed + b_signed);
  assign sum_abs  = sum[25] ? -sum : sum;

  // carry out of bit 23 moves right by one, sticky keeps the dropped bit
  assign m_carry = sum_abs[24] ? {1'b0, sum_abs[25:-1], |sum_abs[-2:-3]} : sum_abs;
  assign e_carry = exp_big + EXP_W'(sum_abs[24]);

  // left normalize, but never below biased exponent 0
  assign zcount     = lzc({m_carry[23:-3], 21'd0});
  assign norm_shift = (e_carry < EXP_W'(zcount)) ? e_carry[5:0] : zcount;
  assign m_shl      = m_carry << norm_shift;
  assign e_shl      = e_carry - EXP_W'(norm_shift);

  // exponent 0 encodes 0.f x 2^-126, one more right step
  assign m_norm = (e_shl == '0) ? {1'b0, m_shl[25:-1], |m_shl[-2:-3]} : m_shl;

  // round to nearest, ties to even
  assign {guard, rnd, sticky} = m_norm[-1:-3];
  assign round_up  = guard & (rnd | sticky | m_norm[0]);
  assign m_rounded = m_norm[25:0] + 26'(round_up);

  // rounding carry renormalizes
  assign m_renorm = m_rounded[24] ? (m_rounded >> 1) : m_rounded;
  assign e_renorm = e_shl + EXP_W'(m_rounded[24]);
  assign e_final  = (e_renorm == '0 && m_renorm[23]) ? EXP_W'(1) : e_renorm;  // subnormal rounded up

  always_comb begin
    if (a.cls.nan) begin
      res = a.raw;
    end else if (b.cls.nan) begin
      res = b.raw;
    end else if (a.cls.inf && b.cls.inf && (a.sign ^ b.sign ^ sub)) begin
      res = {1'b0, {EXP_W{1'b1}}, QNAN_MAN};  // inf - inf
    end else if (a.cls.inf && b.cls.inf) begin
      res = {a.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};  // both push the same way
    end else if (a.cls.inf) begin
      res = {a.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    end else if (b.cls.inf) begin
      res = {b.sign ^ sub, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    end else if (m_renorm == '0) begin
      res = '0;  // exact cancellation is +0
    end else begin
      res = {sum[25], e_final, m_renorm[MAN_W-1:0]};
    end
  end

endmodule

// ==== logic/fp_mul.sv ====
`timescale 1ns/10ps

module fp_mul import fpu_pkg::*; (
  input  fp_operand_t a,
  input  fp_operand_t b,
  output fp32_t       res
);

  // exponents here are biased and signed, so 0 and below means subnormal
  logic                sign;
  logic [47:0]         product;     // 2.46 fixed point, unit at bit 46
  logic signed [9:0]   exp_sum;
  logic signed [9:0]   exp_adj;
  logic [5:0]          zcount;
  logic [47:0]         m_shl;       // hidden bit at 47 after this
  logic signed [9:0]   e_shl;
  logic                underflow;
  logic [9:0]          rshift;
  logic [47:0]         m_norm;
  logic                lost;        // ones shifted out on the subnormal path
  logic signed [9:0]   e_norm;
  logic                guard;
  logic                sticky;
  logic                round_up;
  logic [24:0]         m_rounded;
  logic [24:0]         m_renorm;
  logic signed [9:0]   e_renorm;
  logic [EXP_W-1:0]    e_field;

  assign sign    = a.sign ^ b.sign;
  assign product = a.sig * b.sig;

  assign exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'(EXP_BIAS);
  assign exp_adj = exp_sum + $signed({9'd0, product[47]});  // 1x.xx product

  // leading zeros move the hidden bit up to 47
  // a product with bit 46 set is already 1.x, so only the excess shift counts
  assign zcount = lzc(product);
  assign m_shl  = product << zcount;
  assign e_shl  = product[47] ? exp_adj : (exp_adj - $signed({4'd0, zcount}) + 10'sd1);

  // back up to biased exponent 0, then once more for the 0.f encoding
  assign underflow = (e_shl <= 10'sd0);
  assign rshift    = underflow ? 10'(10'sd1 - e_shl) : 10'd0;
  assign m_norm    = m_shl >> rshift;
  assign lost      = |(m_shl & ~({48{1'b1}} << rshift));
  assign e_norm    = underflow ? 10'sd0 : e_shl;

  // round upper 24 bits, ties to even
  assign guard     = m_norm[23];
  assign sticky    = |m_norm[22:0] | lost;
  assign round_up  = guard & (sticky | m_norm[24]);
  assign m_rounded = {1'b0, m_norm[47:24]} + 25'(round_up);

  // renormalize on rounding carry
  assign m_renorm = m_rounded[24] ? (m_rounded >> 1) : m_rounded;
  assign e_renorm = e_norm + $signed({9'd0, m_rounded[24]});
  assign e_field  = (e_renorm == 10'sd0 && m_renorm[23]) ? EXP_W'(1) : e_renorm[EXP_W-1:0];

  always_comb begin
    if (a.cls.nan) begin
      res = a.raw;
    end else if (b.cls.nan) begin
      res = b.raw;
    end else if ((a.cls.zero && b.cls.inf) || (a.cls.inf && b.cls.zero)) begin
      res = {1'b0, {EXP_W{1'b1}}, QNAN_MAN};  // 0 x inf
    end else if (a.cls.inf || b.cls.inf) begin
      res = {sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    end else if (a.cls.zero || b.cls.zero) begin
      res = {sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};  // signed zero
    end else begin
      res = {sign, e_field, m_renorm[MAN_W-1:0]};
    end
  end

endmodule

// ==== logic/fpu_top.sv ====
`timescale 1ns/10ps

module fpu_top import fpu_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  fp32_t   a_operand,
  input  fp32_t   b_operand,
  input  fpu_op_e operation,        // level, sampled every rising edge
  output fp32_t   ieee_packet_out   // result of the previous cycle's inputs
);

  fp_operand_t a_unp;
  fp_operand_t b_unp;
  fp32_t       addsub_res;
  fp32_t       mul_res;
  fp32_t       result_d;   // selected unit result, register input
  logic        sub;

  // operand decode
  fp_unpack u_unpack_a (
    .word (a_operand),
    .opnd (a_unp)
  );

  fp_unpack u_unpack_b (
    .word (b_operand),
    .opnd (b_unp)
  );

  assign sub = (operation == op_sub);  // adder runs a - b

  fp_addsub u_addsub (
    .a   (a_unp),
    .b   (b_unp),
    .sub (sub),
    .res (addsub_res)
  );

  fp_mul u_mul (
    .a   (a_unp),
    .b   (b_unp),
    .res (mul_res)
  );

  assign result_d = (operation == op_mul) ? mul_res : addsub_res;

  // single pipeline stage, one cycle latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ieee_packet_out <= '0;
    end else begin
      ieee_packet_out <= result_d;
    end
  end

endmodule

// ==== verif/fpu_ref.svh ====
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// expected results from exact integer values, then one rounding step

function automatic logic is_nan_word(input fp32_t w);
  return (w.exp == 8'hff) && (w.man != '0);
endfunction

function automatic logic is_inf_word(input fp32_t w);
  return (w.exp == 8'hff) && (w.man == '0);
endfunction

function automatic logic is_zero_word(input fp32_t w);
  return (w.exp == 8'h00) && (w.man == '0);
endfunction

// index of the highest set bit, -1 for zero
function automatic int msb_pos(input logic [63:0] v);
  int p;
  p = -1;
  for (int i = 0; i < 64; i++) begin
    if (v[i]) begin
      p = i;
    end
  end
  return p;
endfunction

// drop sh low bits, round to nearest, ties go to the even value
function automatic logic [63:0] rne_shift(input logic [63:0] v, input int sh);
  logic [63:0] keep;
  logic [63:0] rem;
  logic [63:0] half;
  keep = v >> sh;
  rem  = v & ((64'd1 << sh) - 64'd1);
  half = 64'd1 << (sh - 1);
  if (rem > half || (rem == half && keep[0])) begin
    keep = keep + 64'd1;
  end
  return keep;
endfunction

function automatic fp32_t ref_addsub(input fp32_t a, input fp32_t b, input logic sub);
  logic        b_sign;   // sign of b as it enters the sum
  logic [63:0] siga;
  logic [63:0] sigb;
  longint      sa;
  longint      sb;
  longint      s;
  logic [63:0] mag;
  logic [63:0] keep;
  int          ea;
  int          eb;
  int          elsb;     // exponent of the common lsb
  int          p;
  int          e;
  b_sign = b.sign ^ sub;
  if (is_nan_word(a)) return a;
  if (is_nan_word(b)) return b;
  if (is_inf_word(a) && is_inf_word(b)) begin
    if (a.sign != b_sign) return fp32_t'(32'h7fc00000);  // inf - inf
    return {a.sign, 8'hff, 23'h0};
  end
  if (is_inf_word(a)) return a;
  if (is_inf_word(b)) return {b_sign, 8'hff, 23'h0};
  siga = 64'({(a.exp != 8'h00), a.man});
  sigb = 64'({(b.exp != 8'h00), b.man});
  ea = (a.exp == 8'h00) ? 1 : int'(a.exp);
  eb = (b.exp == 8'h00) ? 1 : int'(b.exp);
  if (siga == 0) ea = eb;   // a zero term adds nothing, any scale works
  if (sigb == 0) eb = ea;
  elsb = (ea < eb) ? ea : eb;
  sa = longint'(siga << (ea - elsb));   // exact, diff stays within 30
  sb = longint'(sigb << (eb - elsb));
  s  = (a.sign ? -sa : sa) + (b_sign ? -sb : sb);
  if (s == 0) return '0;   // cancellation is +0
  mag = 64'((s < 0) ? -s : s);
  p   = msb_pos(mag);
  if (p > 23) begin
    keep = rne_shift(mag, p - 23);
    e    = elsb + p - 23;
  end else begin
    keep = mag << (23 - p);
    e    = elsb - (23 - p);
  end
  if (keep[24]) begin   // rounded up to the next power of two
    keep = keep >> 1;
    e    = e + 1;
  end
  return {(s < 0), 8'(e), keep[22:0]};
endfunction

function automatic fp32_t ref_mul(input fp32_t a, input fp32_t b);
  logic        sign;
  logic [63:0] prod;
  logic [63:0] keep;
  int          e;
  sign = a.sign ^ b.sign;
  if (is_nan_word(a)) return a;
  if (is_nan_word(b)) return b;
  if ((is_zero_word(a) && is_inf_word(b)) || (is_inf_word(a) && is_zero_word(b))) begin
    return fp32_t'(32'h7fc00000);
  end
  if (is_inf_word(a) || is_inf_word(b)) return {sign, 8'hff, 23'h0};
  if (is_zero_word(a) || is_zero_word(b)) return {sign, 8'h00, 23'h0};
  prod = 64'({1'b1, a.man}) * 64'({1'b1, b.man});   // normal operands only
  e    = int'(a.exp) + int'(b.exp) - 127;
  if (prod[47]) begin
    keep = rne_shift(prod, 24);
    e    = e + 1;
  end else begin
    keep = rne_shift(prod, 23);
  end
  if (keep[24]) begin
    keep = keep >> 1;
    e    = e + 1;
  end
  return {sign, 8'(e), keep[22:0]};
endfunction

function automatic fp32_t ref_fpu(input fpu_op_e op, input fp32_t a, input fp32_t b);
  case (op)
    op_add:  return ref_addsub(a, b, 1'b0);
    op_sub:  return ref_addsub(a, b, 1'b1);
    default: return ref_mul(a, b);
  endcase
endfunction

`endif

// ==== verif/fpu_tb.sv ====
`timescale 1ns/10ps

module fpu_tb import fpu_pkg::*; ();

  localparam int          N_RAND     = 600;   // op rotates add, sub, mul every vector
  localparam int          RST_CYCLES = 16;
  localparam logic [31:0] SEED       = 32'h478f82ce;

  typedef struct packed {
    fpu_op_e op;
    fp32_t   a;
    fp32_t   b;
    fp32_t   expected;
  } vec_t;

  logic    clk;
  logic    arst_n;
  fp32_t   a_operand;
  fp32_t   b_operand;
  fpu_op_e operation;
  fp32_t   ieee_packet_out;

  vec_t vec_list[$];   // all vectors in drive order
  vec_t exp_q[$];      // driven but not yet checked
  int   n_vec;
  logic vectors_ready;
  logic driving;

  `include "fpu_ref.svh"

  fpu_top u_fpu_top (
    .clk             (clk),
    .arst_n          (arst_n),
    .a_operand       (a_operand),
    .b_operand       (b_operand),
    .operation       (operation),
    .ieee_packet_out (ieee_packet_out)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns period

  task automatic check_word(input fp32_t got, input fp32_t want, input string what);
    if (got !== want) begin
      $display("[FAIL] %0t ns %s: got %08h expected %08h", $time, what, got, want);
      $display("TEST FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  function automatic fp32_t random_word(input int e);
    fp32_t w;
    w.sign = 1'($urandom_range(1));
    w.exp  = 8'(e);
    w.man  = 23'($urandom);
    return w;
  endfunction

  task automatic add_vector(input fpu_op_e op, input fp32_t a, input fp32_t b);
    vec_t v;
    v.op       = op;
    v.a        = a;
    v.b        = b;
    v.expected = ref_fpu(op, a, b);
    vec_list.push_back(v);
  endtask

  task automatic build_vectors();
    fp32_t   a;
    fp32_t   b;
    fpu_op_e op;
    int      ea;
    int      eb;
    // special operands
    add_vector(op_add, 32'h7fc00001, 32'h3f800000);   // quiet nan a passes through
    add_vector(op_add, 32'h3f800000, 32'hff812345);   // signaling nan b kept as is
    add_vector(op_mul, 32'h7f800001, 32'h7fa00000);
    add_vector(op_sub, 32'h7f800000, 32'h7f800000);   // inf - inf
    add_vector(op_add, 32'h7f800000, 32'hff800000);
    add_vector(op_add, 32'hff800000, 32'hff800000);
    add_vector(op_sub, 32'h7f800000, 32'hff800000);
    add_vector(op_sub, 32'h3f800000, 32'h7f800000);   // b inf flips its sign
    add_vector(op_sub, 32'h3f800000, 32'hff800000);
    add_vector(op_add, 32'hff800000, 32'h40000000);
    add_vector(op_mul, 32'h00000000, 32'h7f800000);   // 0 x inf
    add_vector(op_mul, 32'hff800000, 32'h80000000);
    add_vector(op_mul, 32'hff800000, 32'h40000000);
    add_vector(op_mul, 32'h7f800000, 32'hc0000000);
    add_vector(op_mul, 32'h80000000, 32'h3f800000);   // signed zeros
    add_vector(op_mul, 32'h80000000, 32'h80000000);
    add_vector(op_mul, 32'h00000000, 32'hc2000000);
    add_vector(op_add, 32'h00000000, 32'h3f800000);
    add_vector(op_sub, 32'h80000000, 32'h80000000);
    add_vector(op_sub, 32'h00000000, 32'h3f800000);
    add_vector(op_add, 32'h3f800000, 32'hbf800000);
    add_vector(op_mul, 32'h7fc00000, 32'h00000000);
    // random normals with exponents 100..154 and a difference of at most 30
    for (int i = 0; i < N_RAND; i++) begin
      op = fpu_op_e'(i % 3);
      ea = 100 + $urandom_range(54);
      eb = ea + $urandom_range(60) - 30;
      if (eb < 100) eb = 100;
      if (eb > 154) eb = 154;
      a = random_word(ea);
      b = random_word(eb);
      if (i % 5 == 4) begin
        case (op)
          op_add: b = {~a.sign, a.exp, a.man};   // exact cancellation
          op_sub: b = a;                          // a - a
          default: begin
            a.man[0] = 1'b1;       // odd significand
            b.man    = 23'h400000; // x1.5 ties whenever the product stays below 2
          end
        endcase
      end
      add_vector(op, a, b);
    end
  endtask

  // stimulus
  initial begin
    arst_n        = 1'b0;
    a_operand     = 32'h3f800000;   // 1.0 + 2.0 waits at the inputs through reset
    b_operand     = 32'h40000000;
    operation     = op_add;
    driving       = 1'b0;
    vectors_ready = 1'b0;
    void'($urandom(SEED));
    build_vectors();
    n_vec         = vec_list.size();
    vectors_ready = 1'b1;
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_word(ieee_packet_out, '0, "output during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);   // no edge has loaded the register since release
    check_word(ieee_packet_out, '0, "first cycle after reset");
    foreach (vec_list[i]) begin   // back to back with no idle cycles
      @(posedge clk);
      a_operand <= vec_list[i].a;
      b_operand <= vec_list[i].b;
      operation <= vec_list[i].op;
      exp_q.push_back(vec_list[i]);
      driving = 1'b1;
    end
  end

  // compare process checks one result per cycle one cycle behind the drive
  initial begin
    vec_t v;
    wait (driving);
    @(posedge clk);   // first vector registered here
    for (int j = 0; j < n_vec; j++) begin
      @(negedge clk);
      v = exp_q.pop_front();
      check_word(ieee_packet_out, v.expected,
                 $sformatf("vector %0d op=%0d a=%08h b=%08h", j, v.op, v.a, v.b));
    end
    $display("TEST PASS");
    $finish;
  end

  // watchdog
  initial begin
    wait (vectors_ready);
    #((n_vec + RST_CYCLES + 100) * 10);
    $display("timeout, not all results were checked in time");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== fpu.f ====
+incdir+verif
logic/fpu_pkg.sv
logic/fp_unpack.sv
logic/fp_addsub.sv
logic/fp_mul.sv
logic/fpu_top.sv
verif/fpu_tb.sv
